/* mcu_core.f */
design/mcu_pkg.sv
design/mcu_mem_if.sv
design/mcu_pc.sv
design/mcu_regs.sv
design/mcu_alu.sv
design/mcu_ramctl.sv
design/mcu_ctrl.sv
design/mcu_core.sv
verif/mcu_assert.sv
verif/mcu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= mcu_tb
FILELIST  ?= mcu_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* verif/mcu_tb.sv */
// directed testbench for the core with its memory model and assembler; simulated as top mcu_tb
module mcu_tb;

    logic        clk;
    logic        rst_n    = 1'b0;
    logic        cen      = 1'b1;
    logic        busy     = 1'b0;
    logic [15:0] din      = '0;
    logic [3:0]  dmp_addr = '0;
    logic [23:0] addr;
    logic [15:0] dout;
    logic [1:0]  we;
    logic        halted;
    logic        buserror;
    logic [7:0]  dmp_dout;

    // word memory over byte addresses 0 to 0xffff with its expected image
    logic [15:0] mem [32768];
    logic [15:0] exp_mem [32768];
    logic [15:0] exp_regs [8];
    logic [14:0] load_ptr;
    bit          track;
    bit          stall_en;
    bit          cen_rand;
    bit          freeze;

    mcu_core #(.PC_RSTVAL(24'h000100)) dut (
        .clk(clk), .rst_n(rst_n), .cen(cen), .addr(addr), .din(din), .dout(dout), .we(we),
        .busy(busy), .halted(halted), .buserror(buserror),
        .dmp_addr(dmp_addr), .dmp_dout(dmp_dout)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // memory model answers the bus and lands each store on its completing edge
    initial begin
        void'($urandom(52293));
        forever begin
            @(negedge clk);
            cen  = freeze ? 1'b0 : (cen_rand ? ($urandom_range(2) != 0) : 1'b1);
            busy = stall_en ? ($urandom_range(3) == 0) : 1'b0;
            if (rst_n && cen && !busy && we == 2'b11) begin
                mem[addr[15:1]] = dout;
            end
            din = mem[addr[15:1]];
        end
    end

    task automatic report_failure();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s = 0x%0h, expected 0x%0h", $time, what, got, exp);
            report_failure();
        end
    endtask

    function automatic logic [15:0] fill_word(input int i);
        return 16'(i * 40503) ^ 16'h5a3c;
    endfunction

    function automatic logic [15:0] reg_form(input mcu_pkg::opcode_e op, input int dst,
                                             input int src);
        mcu_pkg::instr_u w;
        w.r.op     = op;
        w.r.dst    = 3'(dst);
        w.r.src    = 3'(src);
        w.r.unused = '0;
        return w;
    endfunction

    function automatic logic [15:0] imm_form(input mcu_pkg::opcode_e op, input int dst,
                                             input int imm);
        mcu_pkg::instr_u w;
        w.i.op  = op;
        w.i.dst = 3'(dst);
        w.i.imm = 9'(imm);
        return w;
    endfunction

    // place one word in the program and step the reference model over it
    task automatic put(input logic [15:0] word);
        mcu_pkg::instr_u w;
        logic [15:0]     a;
        logic [15:0]     b;
        w = word;
        mem[load_ptr] = word;
        exp_mem[load_ptr] = word;
        load_ptr++;
        a = exp_regs[w.r.dst];
        b = exp_regs[w.r.src];
        if (track) begin
            case (w.r.op)
                mcu_pkg::op_ldi: exp_regs[w.i.dst] = {{7{w.i.imm[8]}}, w.i.imm};
                mcu_pkg::op_add: exp_regs[w.r.dst] = a + b;
                mcu_pkg::op_sub: exp_regs[w.r.dst] = a - b;
                mcu_pkg::op_and: exp_regs[w.r.dst] = a & b;
                mcu_pkg::op_xor: exp_regs[w.r.dst] = a ^ b;
                mcu_pkg::op_ld:  exp_regs[w.r.dst] = exp_mem[b[15:1]];
                mcu_pkg::op_st:  exp_mem[b[15:1]] = a;
                default: ;
            endcase
        end
    endtask

    // reset is held while the next program is loaded
    task automatic start_reset(input bit stalls, input bit random_cen);
        @(negedge clk);
        rst_n    = 1'b0;
        stall_en = stalls;
        cen_rand = random_cen;
        track    = 1'b1;
        load_ptr = 15'h0080;
        for (int i = 0; i < 32768; i++) begin
            mem[15'(i)]     = fill_word(i);
            exp_mem[15'(i)] = fill_word(i);
        end
        for (int r = 0; r < 8; r++) begin
            exp_regs[3'(r)] = '0;
        end
    endtask

    task automatic release_reset();
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic wait_halted(input int limit);
        int n;
        n = 0;
        while (!halted && n < limit) begin
            @(negedge clk);
            n++;
        end
        assert (halted) else begin
            $display("Timeout: core did not halt within %0d cycles", limit);
            report_failure();
        end
    endtask

    task automatic read_reg(input int r, output logic [15:0] value);
        @(negedge clk);
        dmp_addr = 4'(2 * r);
        #5;
        value[7:0] = dmp_dout;
        @(negedge clk);
        dmp_addr = 4'(2 * r + 1);
        #5;
        value[15:8] = dmp_dout;
    endtask

    task automatic compare_state();
        logic [15:0] got;
        for (int r = 0; r < 8; r++) begin
            read_reg(r, got);
            check_value($sformatf("r%0d", r), 32'(got), 32'(exp_regs[3'(r)]));
        end
        for (int i = 0; i < 32768; i++) begin
            if (mem[15'(i)] !== exp_mem[15'(i)]) begin
                check_value($sformatf("mem[0x%04h]", 2 * i), 32'(mem[15'(i)]),
                            32'(exp_mem[15'(i)]));
            end
        end
    endtask

    task automatic load_alu_program();
        put(imm_form(mcu_pkg::op_ldi, 1, 100));
        put(imm_form(mcu_pkg::op_ldi, 2, -3));
        put(imm_form(mcu_pkg::op_ldi, 3, 255));
        put(imm_form(mcu_pkg::op_ldi, 4, -256));
        put(reg_form(mcu_pkg::op_add, 1, 2));
        put(reg_form(mcu_pkg::op_sub, 2, 3));
        put(reg_form(mcu_pkg::op_and, 4, 2));
        put(reg_form(mcu_pkg::op_xor, 3, 4));
        put(reg_form(mcu_pkg::op_add, 5, 4));
        put(reg_form(mcu_pkg::op_sub, 6, 1));
        put(reg_form(mcu_pkg::op_add, 2, 2));
        put(reg_form(mcu_pkg::op_xor, 7, 3));
        put(imm_form(mcu_pkg::op_halt, 0, 0));
    endtask

    task automatic finish_run(input bit expect_error);
        wait_halted(4000);
        check_value("buserror", 32'(buserror), 32'(expect_error));
        compare_state();
    endtask

    // core held frozen by cen so the reset state can be dumped
    task automatic check_after_reset();
        logic [15:0] got;
        freeze = 1'b1;
        start_reset(1'b0, 1'b0);
        put(imm_form(mcu_pkg::op_halt, 0, 0));
        release_reset();
        check_value("we", 32'(we), 32'h0);
        check_value("halted", 32'(halted), 32'h0);
        check_value("buserror", 32'(buserror), 32'h0);
        for (int r = 0; r < 8; r++) begin
            read_reg(r, got);
            check_value($sformatf("r%0d", r), 32'(got), 32'h0);
        end
        check_value("addr", 32'(addr), 32'h000100);
        freeze = 1'b0;
        finish_run(1'b0);
    endtask

    task automatic alu_chain_test();
        start_reset(1'b0, 1'b0);
        load_alu_program();
        release_reset();
        finish_run(1'b0);
    endtask

    task automatic load_store_test();
        start_reset(1'b1, 1'b0);
        mem[15'h0038]     = 16'hbeef;
        exp_mem[15'h0038] = 16'hbeef;
        put(imm_form(mcu_pkg::op_ldi, 1, 'h60));
        put(imm_form(mcu_pkg::op_ldi, 2, 'h62));
        put(imm_form(mcu_pkg::op_ldi, 3, -77));
        put(imm_form(mcu_pkg::op_ldi, 4, 171));
        put(imm_form(mcu_pkg::op_ldi, 0, 'h70));
        put(reg_form(mcu_pkg::op_st, 3, 1));
        put(reg_form(mcu_pkg::op_st, 4, 2));
        put(reg_form(mcu_pkg::op_ld, 5, 1));
        put(reg_form(mcu_pkg::op_ld, 6, 2));
        put(reg_form(mcu_pkg::op_ld, 7, 0));
        put(reg_form(mcu_pkg::op_add, 5, 6));
        put(imm_form(mcu_pkg::op_halt, 0, 0));
        release_reset();
        finish_run(1'b0);
    endtask

    // r1 counts down from 5 and each pass stores it at r3
    task automatic countdown_loop_test();
        start_reset(1'b1, 1'b0);
        put(imm_form(mcu_pkg::op_ldi, 1, 5));
        put(imm_form(mcu_pkg::op_ldi, 2, 1));
        put(imm_form(mcu_pkg::op_ldi, 3, 'h40));
        put(imm_form(mcu_pkg::op_ldi, 4, 2));
        track = 1'b0;
        put(reg_form(mcu_pkg::op_st, 1, 3));
        put(reg_form(mcu_pkg::op_add, 3, 4));
        put(reg_form(mcu_pkg::op_sub, 1, 2));
        put(imm_form(mcu_pkg::op_jrnz, 0, -4));
        put(imm_form(mcu_pkg::op_halt, 0, 0));
        for (int k = 0; k < 5; k++) begin
            exp_mem[15'(32 + k)] = 16'(5 - k);
        end
        exp_regs[1] = 16'h0000;
        exp_regs[3] = 16'h004a;
        release_reset();
        finish_run(1'b0);
    endtask

    task automatic illegal_opcode_test();
        start_reset(1'b0, 1'b0);
        put(imm_form(mcu_pkg::op_ldi, 1, 7));
        put(imm_form(mcu_pkg::op_ldi, 2, 'h50));
        put(16'ha123);
        // nothing past the bad word may execute
        track = 1'b0;
        put(reg_form(mcu_pkg::op_st, 1, 2));
        put(imm_form(mcu_pkg::op_ldi, 1, 55));
        put(imm_form(mcu_pkg::op_halt, 0, 0));
        release_reset();
        wait_halted(4000);
        repeat (20) @(negedge clk);
        finish_run(1'b1);
    endtask

    task automatic cen_gating_test();
        start_reset(1'b1, 1'b1);
        load_alu_program();
        release_reset();
        finish_run(1'b0);
    endtask

    initial begin
        check_after_reset();
        alu_chain_test();
        load_store_test();
        countdown_loop_test();
        illegal_opcode_test();
        cen_gating_test();
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* verif/mcu_assert.sv */
// concurrent checks on the core's bus and status pins, bound into every mcu_core instance
module mcu_assert (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       cen,
    input logic [mcu_pkg::addr_w-1:0] addr,
    input logic [1:0]                 we,
    input logic                       busy,
    input logic                       halted,
    input logic                       buserror
);

    // stores always write the full word
    we_legal: assert property (@(posedge clk) disable iff (!rst_n) we == 2'b00 || we == 2'b11)
        else $error("we carries a partial byte enable");

    addr_even: assert property (@(posedge clk) disable iff (!rst_n) addr[0] == 1'b0)
        else $error("bus address is odd");

    // sticky until reset
    halted_sticky: assert property (@(posedge clk) disable iff (!rst_n) $past(halted) |-> halted)
        else $error("halted fell without reset");

    error_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        $past(buserror) |-> buserror)
        else $error("buserror fell without reset");

    // a stalled store keeps its address and enables
    store_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (cen && busy && we == 2'b11) |=> (we == 2'b11 && $stable(addr)))
        else $error("store changed while busy was high");

    frozen_bus: assert property (@(posedge clk) disable iff (!rst_n)
        !cen |=> ($stable(addr) && $stable(we)))
        else $error("bus moved on a cycle with cen low");

endmodule

bind mcu_core mcu_assert u_assert (
    .clk(clk), .rst_n(rst_n), .cen(cen), .addr(addr), .we(we),
    .busy(busy), .halted(halted), .buserror(buserror)
);

/* design/mcu_core.sv */
// top level of the 16-bit core, ties the FSM, datapath and bus master to the external pins
module mcu_core #(
    parameter logic [mcu_pkg::addr_w-1:0] PC_RSTVAL = '0
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cen,

    output logic [mcu_pkg::addr_w-1:0] addr,
    input  logic [mcu_pkg::data_w-1:0] din,
    output logic [mcu_pkg::data_w-1:0] dout,
    output logic [1:0]                 we,
    input  logic                       busy,

    output logic                       halted,
    output logic                       buserror,

    input  logic [3:0]                 dmp_addr,
    output logic [7:0]                 dmp_dout
);

    mcu_mem_if mem_bus ();

    logic [mcu_pkg::addr_w-1:0] pc;
    logic                       pc_inc, pc_rel;
    logic [8:0]                 rel_off;
    logic [2:0]                 rs_a, rs_b, rd_sel;
    logic                       rd_we, wsel;
    logic [mcu_pkg::data_w-1:0] rd_a, rd_b, imm, alu_res;
    mcu_pkg::alu_op_e           alu_sel;
    logic                       flag_we, z;

    mcu_ctrl u_ctrl (
        .clk      ( clk      ), .rst_n   ( rst_n   ), .cen  ( cen  ),
        .mem      ( mem_bus  ),
        .pc       ( pc       ), .pc_inc  ( pc_inc  ), .pc_rel   ( pc_rel   ),
        .rel_off  ( rel_off  ),
        .rs_a     ( rs_a     ), .rs_b    ( rs_b    ), .rd_sel   ( rd_sel   ),
        .rd_we    ( rd_we    ), .wsel    ( wsel    ),
        .rd_a     ( rd_a     ), .rd_b    ( rd_b    ),
        .alu_sel  ( alu_sel  ), .imm     ( imm     ), .flag_we  ( flag_we  ),
        .z        ( z        ),
        .halted   ( halted   ), .buserror( buserror)
    );

    mcu_pc #(.PC_RSTVAL(PC_RSTVAL)) u_pc (
        .clk      ( clk      ), .rst_n   ( rst_n   ), .cen  ( cen  ),
        .inc      ( pc_inc   ), .rel     ( pc_rel  ), .rel_off  ( rel_off  ),
        .pc       ( pc       )
    );

    mcu_regs u_regs (
        .clk      ( clk      ), .rst_n   ( rst_n   ), .cen  ( cen  ),
        .rs_a     ( rs_a     ), .rs_b    ( rs_b    ), .rd_sel   ( rd_sel   ),
        .rd_we    ( rd_we    ), .wsel    ( wsel    ),
        .alu_res  ( alu_res  ), .mem_data( mem_bus.rdata ),
        .rd_a     ( rd_a     ), .rd_b    ( rd_b    ),
        .dmp_addr ( dmp_addr ), .dmp_dout( dmp_dout)
    );

    // only the pass operation takes the immediate
    mcu_alu u_alu (
        .clk      ( clk      ), .rst_n   ( rst_n   ), .cen  ( cen  ),
        .a        ( rd_a     ), .b       ( rd_b    ), .imm  ( imm  ),
        .sel      ( alu_sel  ), .use_imm ( alu_sel == mcu_pkg::alu_pass ),
        .flag_we  ( flag_we  ),
        .res      ( alu_res  ), .z       ( z       )
    );

    mcu_ramctl #(.PC_RSTVAL(PC_RSTVAL)) u_ramctl (
        .clk      ( clk      ), .rst_n   ( rst_n   ), .cen  ( cen  ),
        .mem      ( mem_bus  ),
        .addr     ( addr     ), .din     ( din     ), .dout ( dout ),
        .we       ( we       ), .busy    ( busy    )
    );

endmodule

/* design/mcu_ctrl.sv */
// fetch/execute FSM of the core, decodes each instruction word and drives all datapath strobes
module mcu_ctrl (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cen,

    mcu_mem_if.ctrl                    mem,

    input  logic [mcu_pkg::addr_w-1:0] pc,
    output logic                       pc_inc,
    output logic                       pc_rel,
    output logic [8:0]                 rel_off,

    output logic [2:0]                 rs_a,
    output logic [2:0]                 rs_b,
    output logic [2:0]                 rd_sel,
    output logic                       rd_we,
    output logic                       wsel,
    input  logic [mcu_pkg::data_w-1:0] rd_a,
    input  logic [mcu_pkg::data_w-1:0] rd_b,

    output mcu_pkg::alu_op_e           alu_sel,
    output logic [mcu_pkg::data_w-1:0] imm,
    output logic                       flag_we,
    input  logic                       z,

    output logic                       halted,
    output logic                       buserror
);

    localparam logic [2:0] st_fetch = 3'd0;
    localparam logic [2:0] st_fwait = 3'd1;
    localparam logic [2:0] st_exec  = 3'd2;
    localparam logic [2:0] st_mwait = 3'd3;
    localparam logic [2:0] st_stop  = 3'd4;

    logic [2:0]       state;
    mcu_pkg::instr_u  ir;
    mcu_pkg::opcode_e op;
    logic             in_exec;
    logic             is_alu;
    logic             legal;
    logic             is_mem;

    assign op      = ir.r.op;
    assign in_exec = (state == st_exec);
    assign is_mem  = (op == mcu_pkg::op_ld) || (op == mcu_pkg::op_st);

    // opcode decode
    always_comb begin
        alu_sel = mcu_pkg::alu_pass;
        is_alu  = 1'b1;
        legal   = 1'b1;
        case (op)
            mcu_pkg::op_ldi: alu_sel = mcu_pkg::alu_pass;
            mcu_pkg::op_add: alu_sel = mcu_pkg::alu_add;
            mcu_pkg::op_sub: alu_sel = mcu_pkg::alu_sub;
            mcu_pkg::op_and: alu_sel = mcu_pkg::alu_and;
            mcu_pkg::op_xor: alu_sel = mcu_pkg::alu_xor;
            mcu_pkg::op_ld, mcu_pkg::op_st, mcu_pkg::op_jrnz, mcu_pkg::op_halt: begin
                is_alu = 1'b0;
            end
            default: begin
                is_alu = 1'b0;
                legal  = 1'b0;
            end
        endcase
    end

    // register view for alu and memory ops, immediate view for ldi and jrnz
    assign rs_a    = is_mem ? ir.r.src : ir.r.dst;
    assign rs_b    = is_mem ? ir.r.dst : ir.r.src;
    assign rd_sel  = ir.r.dst;
    assign imm     = {{(mcu_pkg::data_w-9){ir.i.imm[8]}}, ir.i.imm};
    assign rel_off = ir.i.imm;

    // loaded data is written back when the bus access completes
    assign wsel    = (state == st_mwait);
    assign rd_we   = (in_exec && is_alu) || (wsel && mem.rdy && op == mcu_pkg::op_ld);
    assign flag_we = in_exec && is_alu;

    assign pc_inc  = (state == st_fwait) && mem.rdy;
    assign pc_rel  = in_exec && (op == mcu_pkg::op_jrnz) && !z;

    assign mem.rd    = (state == st_fetch) || (in_exec && op == mcu_pkg::op_ld);
    assign mem.wr    = in_exec && (op == mcu_pkg::op_st);
    assign mem.wdata = rd_b;
    assign mem.req_addr = (state == st_fetch) ? pc :
                          {{(mcu_pkg::addr_w-mcu_pkg::data_w){1'b0}}, rd_a};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_fetch;
            halted   <= 1'b0;
            buserror <= 1'b0;
        end else if (cen) begin
            case (state)
                st_fetch: state <= st_fwait;
                st_fwait: if (mem.rdy) state <= st_exec;
                st_exec: begin
                    if (!legal) begin
                        halted   <= 1'b1;
                        buserror <= 1'b1;
                        state    <= st_stop;
                    end else if (op == mcu_pkg::op_halt) begin
                        halted <= 1'b1;
                        state  <= st_stop;
                    end else if (is_mem) begin
                        state <= st_mwait;
                    end else begin
                        state <= st_fetch;
                    end
                end
                st_mwait: if (mem.rdy) state <= st_fetch;
                default:  state <= st_stop;
            endcase
        end
    end

    // instruction register
    always_ff @(posedge clk) begin
        if (cen && pc_inc) begin
            ir <= mem.rdata;
        end
    end

endmodule

/* design/mcu_ramctl.sv */
// external bus master, runs one access per request and stretches it while busy is high
module mcu_ramctl #(
    parameter logic [mcu_pkg::addr_w-1:0] PC_RSTVAL = '0
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cen,

    mcu_mem_if.ram                     mem,

    output logic [mcu_pkg::addr_w-1:0] addr,
    input  logic [mcu_pkg::data_w-1:0] din,
    output logic [mcu_pkg::data_w-1:0] dout,
    output logic [1:0]                 we,
    input  logic                       busy
);

    logic active;
    logic start;
    logic done;

    assign start = !active && (mem.rd || mem.wr);
    assign done  = active && !busy;

    // addr stays at the last access while idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active  <= 1'b0;
            addr    <= PC_RSTVAL;
            we      <= 2'b00;
            mem.rdy <= 1'b0;
        end else if (cen) begin
            mem.rdy <= done;
            if (start) begin
                active <= 1'b1;
                addr   <= mem.req_addr;
                we     <= mem.wr ? 2'b11 : 2'b00;
            end else if (done) begin
                active <= 1'b0;
                we     <= 2'b00;
            end
        end
    end

    // write data and captured read data
    always_ff @(posedge clk) begin
        if (cen && start) begin
            dout <= mem.wdata;
        end
        if (cen && done) begin
            mem.rdata <= din;
        end
    end

endmodule

/* design/mcu_alu.sv */
// word ALU for the register and immediate instructions, keeps the zero flag
module mcu_alu (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cen,

    input  logic [mcu_pkg::data_w-1:0] a,
    input  logic [mcu_pkg::data_w-1:0] b,
    input  logic [mcu_pkg::data_w-1:0] imm,
    input  mcu_pkg::alu_op_e           sel,
    input  logic                       use_imm,
    input  logic                       flag_we,

    output logic [mcu_pkg::data_w-1:0] res,
    output logic                       z
);

    logic [mcu_pkg::data_w-1:0] op_b;

    // second operand, immediate for ldi
    assign op_b = use_imm ? imm : b;

    // all results wrap at 16 bits
    always_comb begin
        case (sel)
            mcu_pkg::alu_add: res = a + op_b;
            mcu_pkg::alu_sub: res = a - op_b;
            mcu_pkg::alu_and: res = a & op_b;
            mcu_pkg::alu_xor: res = a ^ op_b;
            default:          res = op_b;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            z <= 1'b0;
        end else if (cen && flag_we) begin
            z <= (res == '0);
        end
    end

endmodule

/* design/mcu_regs.sv */
// eight word register file with two read ports, one write port and a byte-wide debug dump
module mcu_regs (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cen,

    input  logic [2:0]                 rs_a,
    input  logic [2:0]                 rs_b,
    input  logic [2:0]                 rd_sel,
    input  logic                       rd_we,
    input  logic                       wsel,

    input  logic [mcu_pkg::data_w-1:0] alu_res,
    input  logic [mcu_pkg::data_w-1:0] mem_data,

    output logic [mcu_pkg::data_w-1:0] rd_a,
    output logic [mcu_pkg::data_w-1:0] rd_b,

    input  logic [3:0]                 dmp_addr,
    output logic [7:0]                 dmp_dout
);

    logic [mcu_pkg::data_w-1:0] regs [8];
    logic [mcu_pkg::data_w-1:0] wdata;
    logic [mcu_pkg::data_w-1:0] dmp_word;

    // write source, memory for loads
    assign wdata = wsel ? mem_data : alu_res;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (cen && rd_we) begin
            regs[rd_sel] <= wdata;
        end
    end

    // asynchronous read ports
    assign rd_a = regs[rs_a];
    assign rd_b = regs[rs_b];

    // dump port, upper bits pick the register, bit 0 the byte
    // not gated by cen so the testbench can read a frozen core
    assign dmp_word = regs[dmp_addr[3:1]];
    assign dmp_dout = dmp_addr[0] ? dmp_word[15:8] : dmp_word[7:0];

endmodule

/* design/mcu_pc.sv */
// program counter, steps by one word after each fetch or jumps relative on a taken branch
module mcu_pc #(
    parameter logic [mcu_pkg::addr_w-1:0] PC_RSTVAL = '0
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cen,

    input  logic                       inc,
    input  logic                       rel,
    input  logic [8:0]                 rel_off,

    output logic [mcu_pkg::addr_w-1:0] pc
);

    logic [mcu_pkg::addr_w-1:0] offset;

    // word offset turned into a byte offset
    assign offset = {{(mcu_pkg::addr_w-10){rel_off[8]}}, rel_off, 1'b0};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= PC_RSTVAL;
        end else if (cen) begin
            if (inc) begin
                pc <= pc + mcu_pkg::addr_w'(2);
            end else if (rel) begin
                pc <= pc + offset;
            end
        end
    end

endmodule

/* design/mcu_mem_if.sv */
// request/response link between the control FSM and the memory controller inside the core
interface mcu_mem_if;

    // request side, rd and wr are single cen-cycle strobes
    logic                       rd;
    logic                       wr;
    logic [mcu_pkg::addr_w-1:0] req_addr;
    logic [mcu_pkg::data_w-1:0] wdata;

    // response side, rdata is valid while rdy is high
    logic [mcu_pkg::data_w-1:0] rdata;
    logic                       rdy;

    modport ctrl (
        output rd, wr, req_addr, wdata,
        input  rdata, rdy
    );

    modport ram (
        input  rd, wr, req_addr, wdata,
        output rdata, rdy
    );

endinterface

/* design/mcu_pkg.sv */
// shared widths, opcodes and instruction formats, used by scoped name across the core and testbench
package mcu_pkg;

    // byte address and data word widths of the external bus
    localparam int addr_w = 24;
    localparam int data_w = 16;

    // top nibble of every instruction word
    typedef enum logic [3:0] {
        op_ldi  = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_and  = 4'd3,
        op_xor  = 4'd4,
        op_ld   = 4'd5,
        op_st   = 4'd6,
        op_jrnz = 4'd7,
        op_halt = 4'd15
    } opcode_e;

    // pass forwards the second operand untouched
    typedef enum logic [2:0] {
        alu_pass = 3'd0,
        alu_add  = 3'd1,
        alu_sub  = 3'd2,
        alu_and  = 3'd3,
        alu_xor  = 3'd4
    } alu_op_e;

    // register form, dst = dst op src
    // for ld and st, src holds the address and dst the data
    typedef struct packed {
        opcode_e    op;
        logic [2:0] dst;
        logic [2:0] src;
        logic [5:0] unused;
    } instr_reg_t;

    // immediate form, used by ldi and jrnz
    typedef struct packed {
        opcode_e           op;
        logic [2:0]        dst;
        logic signed [8:0] imm;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_u;

endpackage
